// ==== hdl/fixedPointPkg.sv ====
`default_nettype none

// Q12.12 fixed-point format shared by every arithmetic block of the tracer
package fixedPointPkg;

  // Integer and fraction widths of the Q format
  localparam int FracBits = 12;
  localparam int IntBits = 12;
  localparam int FixedBits = IntBits + FracBits;

  // Signed Q12.12 value used for vectors, directions and distances
  typedef logic signed [FixedBits-1:0] fixedT;

  // Unsigned Q12.12 value for the DDA track distances, which only ever grow
  typedef logic [FixedBits-1:0] uFixedT;

  // Full-width product of two fixedT values
  typedef logic signed [2*FixedBits-1:0] fixedProdT;

  // Signed integer part of a coordinate, i.e. a map cell index
  typedef logic signed [IntBits-1:0] mapCoordT;

  // The value 1.0
  localparam fixedT OneFixed = fixedT'(1 << FracBits);

endpackage

`default_nettype wire

// ==== hdl/tracerPkg.sv ====
`default_nettype none

// Tracer control encodings, map geometry and per-frame constants
package tracerPkg;

  // Map ROM address widths, giving a 16x16 grid
  localparam int MapColBits = 4;
  localparam int MapRowBits = 4;

  // Per-line sequence of the tracer FSM
  typedef enum logic [3:0] {
    SdxPrep, SdxWait, SdxLoad,
    SdyPrep, SdyWait, SdyLoad,
    TracePrepX, TracePrepY, TraceStep,
    SizePrep, SizeWait, SizeLoad,
    CalcTexU, TraceDone
  } tracerStateT;

  // Operand currently routed into the shared reciprocal
  typedef enum logic [1:0] {
    RcpRayDirX, RcpRayDirY, RcpWallDist
  } rcpSourceT;

  // The deflection accumulates one whole camera plane per line and is scaled back by this
  localparam int AddendShift = 8;

  // Top row sits this many camera-plane steps above the view centre
  localparam int AddendStartScale = 272;

  // Wall half-size in pixels and texture column index
  typedef logic [10:0] wallSizeT;
  typedef logic [5:0] texUT;

endpackage

`default_nettype wire

// ==== hdl/rayDirection.sv ====
`default_nettype none

// Generates the ray direction for the line being traced
module rayDirection import fixedPointPkg::*, tracerPkg::*; (
  input  wire   clk,
  input  wire   do_reset,
  input  wire   i_vsync,
  input  wire   i_lineAdvance,
  input  fixedT i_facingX,
  input  fixedT i_facingY,
  input  fixedT i_vplaneX,
  input  fixedT i_vplaneY,
  output fixedT o_rayDirX,
  output fixedT o_rayDirY,
  output logic  o_rayIncX,
  output logic  o_rayIncY
);

  localparam fixedT StartScale = fixedT'(AddendStartScale);

  // Deflection from the facing vector, kept as a whole number of camera planes
  fixedT rayAddendX;
  fixedT rayAddendY;

  always_ff @(posedge clk) begin
    if (do_reset || i_vsync) begin
      // Start the frame at the top row, well above the view centre
      rayAddendX <= -(i_vplaneX * StartScale);
      rayAddendY <= -(i_vplaneY * StartScale);
    end else if (i_lineAdvance) begin
      // One camera plane further down for the next line
      rayAddendX <= rayAddendX + i_vplaneX;
      rayAddendY <= rayAddendY + i_vplaneY;
    end
  end

  // Arithmetic shift keeps the sign of the deflection
  assign o_rayDirX = i_facingX + (rayAddendX >>> AddendShift);
  assign o_rayDirY = i_facingY + (rayAddendY >>> AddendShift);

  // Set only when the component is strictly positive, so zero walks toward lower cells
  assign o_rayIncX = !o_rayDirX[FixedBits-1] && (o_rayDirX != '0);
  assign o_rayIncY = !o_rayDirY[FixedBits-1] && (o_rayDirY != '0);

endmodule

`default_nettype wire

// ==== hdl/fixedReciprocal.sv ====
`default_nettype none

// Combinational reciprocal of the magnitude of a Q12.12 value
module fixedReciprocal import fixedPointPkg::*; (
  input  fixedT i_data,
  output fixedT o_data
);

  // Largest positive fixedT, returned on overflow and for a zero input
  localparam fixedT FixedMax = fixedT'({1'b0, {(FixedBits-1){1'b1}}});

  // 1.0 squared in raw units, so the raw quotient is already Q12.12
  localparam logic [FixedBits:0] Dividend = {1'b1, {FixedBits{1'b0}}};

  uFixedT absIn;
  logic [FixedBits:0] quotient;

  always_comb begin
    // The most negative input maps onto 2^23, which still fits unsigned
    absIn = i_data[FixedBits-1] ? uFixedT'(-i_data) : uFixedT'(i_data);
    quotient = Dividend / {1'b0, absIn};
    // Any quotient with either of its top two bits set is beyond FixedMax
    if ((absIn == '0) || (quotient[FixedBits:FixedBits-1] != 2'b00)) begin
      o_data = FixedMax;
    end else begin
      o_data = fixedT'(quotient[FixedBits-1:0]);
    end
  end

  // Step distances and wall size are taken as magnitudes downstream
  rcpNeverNegative: assert property (@(i_data) !o_data[FixedBits-1]);

endmodule

`default_nettype wire

// ==== hdl/traceSequencer.sv ====
`default_nettype none

// Per-line FSM that orders the uses of the shared reciprocal and multiplier
module traceSequencer import tracerPkg::*; (
  input  wire         clk,
  input  wire         do_reset,
  input  wire         i_vsync,
  input  wire         i_hmax,
  input  wire         i_mapVal,
  output tracerStateT o_state,
  output rcpSourceT   o_rcpSource,
  output logic        o_lineAdvance
);

  tracerStateT state;
  rcpSourceT rcpSource;

  always_ff @(posedge clk) begin
    if (do_reset || i_vsync) begin
      // Frame restart parks the FSM at the head of a line
      state <= SdxPrep;
      rcpSource <= RcpRayDirX;
    end else begin
      case (state)
        // Step distance along X, reciprocal gets one settle cycle
        SdxPrep: begin
          state <= SdxWait;
          rcpSource <= RcpRayDirX;
        end
        SdxWait: state <= SdxLoad;
        SdxLoad: state <= SdyPrep;
        // Step distance along Y
        SdyPrep: begin
          state <= SdyWait;
          rcpSource <= RcpRayDirY;
        end
        SdyWait: state <= SdyLoad;
        SdyLoad: state <= TracePrepX;
        // Track seeds use the multiplier, one axis per cycle
        TracePrepX: state <= TracePrepY;
        TracePrepY: state <= TraceStep;
        // One map cell per clock until the ROM reports a wall
        TraceStep: begin
          if (i_mapVal) begin
            state <= SizePrep;
          end
        end
        // Reciprocal of the hit distance gives the wall half-size
        SizePrep: begin
          state <= SizeWait;
          rcpSource <= RcpWallDist;
        end
        SizeWait: state <= SizeLoad;
        SizeLoad: state <= CalcTexU;
        CalcTexU: state <= TraceDone;
        // Results are held here for as long as the line end takes to come
        TraceDone: begin
          if (i_hmax) begin
            state <= SdxPrep;
          end
        end
        default: state <= SdxPrep;
      endcase
    end
  end

  assign o_state = state;
  assign o_rcpSource = rcpSource;

  // Same edge on which hitResult presents the line
  assign o_lineAdvance = (state == TraceDone) && i_hmax;

  stateIsLegal: assert property (
    @(posedge clk) disable iff (do_reset)
    state inside {SdxPrep, SdxWait, SdxLoad, SdyPrep, SdyWait, SdyLoad,
                  TracePrepX, TracePrepY, TraceStep, SizePrep, SizeWait,
                  SizeLoad, CalcTexU, TraceDone}
  );

endmodule

`default_nettype wire

// ==== hdl/gridWalker.sv ====
`default_nettype none

// DDA map walk with the shared multiplier, hit distance, side and texture u
module gridWalker import fixedPointPkg::*, tracerPkg::*; (
  input  wire                   clk,
  input  wire                   do_reset,
  input  tracerStateT           i_state,
  input  rcpSourceT             i_rcpSource,
  input  fixedT                 i_playerX,
  input  fixedT                 i_playerY,
  input  fixedT                 i_rayDirX,
  input  fixedT                 i_rayDirY,
  input  wire                   i_rayIncX,
  input  wire                   i_rayIncY,
  input  wire                   i_mapVal,
  input  fixedT                 i_rcpOut,
  output fixedT                 o_rcpIn,
  output logic [MapColBits-1:0] o_mapCol,
  output logic [MapRowBits-1:0] o_mapRow,
  output logic                  o_side,
  output fixedT                 o_wallDist,
  output texUT                  o_texU
);

  fixedT stepDistX;
  fixedT stepDistY;
  uFixedT trackDistX;
  uFixedT trackDistY;
  mapCoordT mapX;
  mapCoordT mapY;
  fixedT hitDist;
  logic side;
  texUT texU;

  fixedT partialX;
  fixedT partialY;
  fixedT mulA;
  fixedT mulB;
  fixedProdT mulProd;
  fixedT wallPos;
  logic texMirror;

  // Hit distance cut to UQ7.9, enough for a size reciprocal of 11 bits
  always_comb begin
    case (i_rcpSource)
      RcpRayDirX: o_rcpIn = i_rayDirX;
      RcpRayDirY: o_rcpIn = i_rayDirY;
      default: o_rcpIn = {{(IntBits-7){1'b0}}, hitDist[FracBits+6:FracBits-9],
                          {(FracBits-9){1'b0}}};
    endcase
  end

  // Distance from the player to the first gridline in the walk direction
  assign partialX = i_rayIncX ? OneFixed - {{IntBits{1'b0}}, i_playerX[FracBits-1:0]}
                              : {{IntBits{1'b0}}, i_playerX[FracBits-1:0]};
  assign partialY = i_rayIncY ? OneFixed - {{IntBits{1'b0}}, i_playerY[FracBits-1:0]}
                              : {{IntBits{1'b0}}, i_playerY[FracBits-1:0]};

  // Operands follow the state that samples the product
  always_comb begin
    case (i_state)
      TracePrepX: begin
        mulA = stepDistX;
        mulB = partialX;
      end
      TracePrepY: begin
        mulA = stepDistY;
        mulB = partialY;
      end
      default: begin
        mulA = side ? i_rayDirX : i_rayDirY;
        mulB = hitDist;
      end
    endcase
  end

  assign mulProd = mulA * mulB;

  // Where along the wall face the ray landed
  assign wallPos = fixedT'(mulProd[FracBits +: FixedBits]) + (side ? i_playerX : i_playerY);
  // Faces seen from behind are mirrored so textures read the same way round
  assign texMirror = side ? i_rayIncY : !i_rayIncX;

  always_ff @(posedge clk) begin
    if (do_reset) begin
      mapX <= '0;
      mapY <= '0;
      hitDist <= '0;
      side <= 1'b0;
      texU <= '0;
    end else begin
      case (i_state)
        SdxLoad: stepDistX <= i_rcpOut;
        SdyLoad: stepDistY <= i_rcpOut;
        TracePrepX: begin
          trackDistX <= uFixedT'(mulProd[FracBits +: FixedBits]);
          mapX <= i_playerX[FixedBits-1:FracBits];
          mapY <= i_playerY[FixedBits-1:FracBits];
        end
        TracePrepY: trackDistY <= uFixedT'(mulProd[FracBits +: FixedBits]);
        TraceStep: begin
          if (!i_mapVal) begin
            // Unsigned compare, a saturated step may push a track past the signed range
            if (trackDistX < trackDistY) begin
              mapX <= i_rayIncX ? mapX + mapCoordT'(1) : mapX - mapCoordT'(1);
              trackDistX <= trackDistX + uFixedT'(stepDistX);
              hitDist <= fixedT'(trackDistX);
              side <= 1'b0;
            end else begin
              mapY <= i_rayIncY ? mapY + mapCoordT'(1) : mapY - mapCoordT'(1);
              trackDistY <= trackDistY + uFixedT'(stepDistY);
              hitDist <= fixedT'(trackDistY);
              side <= 1'b1;
            end
          end
        end
        CalcTexU: texU <= wallPos[FracBits-1 -: $bits(texUT)] ^ {$bits(texUT){texMirror}};
        default: ;
      endcase
    end
  end

  assign o_mapCol = mapX[MapColBits-1:0];
  assign o_mapRow = mapY[MapRowBits-1:0];
  assign o_side = side;
  assign o_wallDist = hitDist;
  assign o_texU = texU;

  // The walk never skips a cell and never moves diagonally
  walkIsUnitStep: assert property (
    @(posedge clk) disable iff (do_reset)
    (i_state == TraceStep) |=>
      ((mapY == $past(mapY)) && ((mapX - $past(mapX)) inside {0, 1, -1})) ||
      ((mapX == $past(mapX)) && ((mapY - $past(mapY)) inside {1, -1}))
  );

endmodule

`default_nettype wire

// ==== hdl/hitResult.sv ====
`default_nettype none

// Holds the wall size and presents the line results at the line end
module hitResult import fixedPointPkg::*, tracerPkg::*; (
  input  wire         clk,
  input  wire         do_reset,
  input  tracerStateT i_state,
  input  wire         i_hmax,
  input  wire         i_side,
  input  fixedT       i_rcpOut,
  input  fixedT       i_wallDist,
  input  texUT        i_texU,
  output logic        o_side,
  output wallSizeT    o_size,
  output texUT        o_texU,
  output fixedT       o_wallDist
);

  wallSizeT size;

  // Reciprocal is only valid while the wall distance is selected
  always_ff @(posedge clk) begin
    if (i_state == SizeLoad) begin
      // Raw bits 14..4 give the half-size in pixels
      size <= i_rcpOut[$bits(wallSizeT)+3:4];
    end
  end

  always_ff @(posedge clk) begin
    if (do_reset) begin
      o_side <= 1'b0;
      o_size <= '0;
      o_texU <= '0;
      o_wallDist <= '0;
    end else if ((i_state == TraceDone) && i_hmax) begin
      // Outputs change only here, so the display sees one line's set at a time
      o_side <= i_side;
      o_size <= size;
      o_texU <= i_texU;
      o_wallDist <= i_wallDist;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/wallTracer.sv ====
`default_nettype none

// Per-scanline wall tracer for a grid-map raycaster
module wallTracer import fixedPointPkg::*, tracerPkg::*; (
  input  wire                   clk,
  input  wire                   do_reset,
  input  wire                   i_vsync,
  input  wire                   i_hmax,
  input  fixedT                 i_playerX,
  input  fixedT                 i_playerY,
  input  fixedT                 i_facingX,
  input  fixedT                 i_facingY,
  input  fixedT                 i_vplaneX,
  input  fixedT                 i_vplaneY,
  output logic [MapColBits-1:0] o_mapCol,
  output logic [MapRowBits-1:0] o_mapRow,
  input  wire                   i_mapVal,
  output logic                  o_side,
  output wallSizeT              o_size,
  output texUT                  o_texU,
  output fixedT                 o_wallDist
);

  tracerStateT state;
  rcpSourceT rcpSource;
  logic lineAdvance;
  fixedT rayDirX;
  fixedT rayDirY;
  logic rayIncX;
  logic rayIncY;
  fixedT rcpIn;
  fixedT rcpOut;
  // Walker results that hitResult holds until the line end
  logic side;
  fixedT wallDist;
  texUT texU;

  rayDirection i_rayDirection (
    .clk           (clk),
    .do_reset      (do_reset),
    .i_vsync       (i_vsync),
    .i_lineAdvance (lineAdvance),
    .i_facingX     (i_facingX),
    .i_facingY     (i_facingY),
    .i_vplaneX     (i_vplaneX),
    .i_vplaneY     (i_vplaneY),
    .o_rayDirX     (rayDirX),
    .o_rayDirY     (rayDirY),
    .o_rayIncX     (rayIncX),
    .o_rayIncY     (rayIncY)
  );

  // One divider serves both step distances and the wall size
  fixedReciprocal i_fixedReciprocal (
    .i_data (rcpIn),
    .o_data (rcpOut)
  );

  traceSequencer i_traceSequencer (
    .clk           (clk),
    .do_reset      (do_reset),
    .i_vsync       (i_vsync),
    .i_hmax        (i_hmax),
    .i_mapVal      (i_mapVal),
    .o_state       (state),
    .o_rcpSource   (rcpSource),
    .o_lineAdvance (lineAdvance)
  );

  gridWalker i_gridWalker (
    .clk         (clk),
    .do_reset    (do_reset),
    .i_state     (state),
    .i_rcpSource (rcpSource),
    .i_playerX   (i_playerX),
    .i_playerY   (i_playerY),
    .i_rayDirX   (rayDirX),
    .i_rayDirY   (rayDirY),
    .i_rayIncX   (rayIncX),
    .i_rayIncY   (rayIncY),
    .i_mapVal    (i_mapVal),
    .i_rcpOut    (rcpOut),
    .o_rcpIn     (rcpIn),
    .o_mapCol    (o_mapCol),
    .o_mapRow    (o_mapRow),
    .o_side      (side),
    .o_wallDist  (wallDist),
    .o_texU      (texU)
  );

  hitResult i_hitResult (
    .clk        (clk),
    .do_reset   (do_reset),
    .i_state    (state),
    .i_hmax     (i_hmax),
    .i_side     (side),
    .i_rcpOut   (rcpOut),
    .i_wallDist (wallDist),
    .i_texU     (texU),
    .o_side     (o_side),
    .o_size     (o_size),
    .o_texU     (o_texU),
    .o_wallDist (o_wallDist)
  );

endmodule

`default_nettype wire

// ==== bench/tbWallTracer.sv ====
`default_nettype none

// Testbench for the wall tracer with a map ROM model and assertion checks
module tbWallTracer import fixedPointPkg::*, tracerPkg::*;;
  timeunit 1ns;
  timeprecision 1ps;

  logic clk = 1'b0;
  logic do_reset, vsync, hmax, mapVal;
  fixedT playerX, playerY, facingX, facingY, vplaneX, vplaneY;
  logic [MapColBits-1:0] mapCol;
  logic [MapRowBits-1:0] mapRow;
  logic side;
  wallSizeT size;
  texUT texU;
  fixedT wallDist;

  // Map model with one bit per cell, indexed by row and then by column
  logic wallMap [16][16];
  integer seed = 81679;
  int errs [1:6];
  int reach [1:6];
  int walkPhase, axisPhase, timedOut, failCount;
  logic seenHmax = 1'b0;
  logic lastAxis = 1'b0;
  logic [MapColBits-1:0] prevCol;
  logic [MapRowBits-1:0] prevRow;
  fixedT expDist;
  wallSizeT expSize;
  texUT expTexU;

  always #10 clk = !clk;

  wallTracer i_dut (
    .clk(clk), .do_reset(do_reset), .i_vsync(vsync), .i_hmax(hmax),
    .i_playerX(playerX), .i_playerY(playerY), .i_facingX(facingX), .i_facingY(facingY),
    .i_vplaneX(vplaneX), .i_vplaneY(vplaneY), .o_mapCol(mapCol), .o_mapRow(mapRow),
    .i_mapVal(mapVal), .o_side(side), .o_size(size), .o_texU(texU), .o_wallDist(wallDist)
  );

  // The ROM answers in the same cycle
  assign mapVal = wallMap[mapRow][mapCol];

  // Tracks which axis the map address moved on last, and how far the stimulus got
  always @(posedge clk) begin
    prevCol <= mapCol;
    prevRow <= mapRow;
    if (mapCol != prevCol) lastAxis <= 1'b0;
    else if (mapRow != prevRow) lastAxis <= 1'b1;
    if (!do_reset) begin
      if (!seenHmax) reach[1]++;
      if (walkPhase != 0 && i_dut.state == TraceStep) reach[2]++;
      if (hmax) begin
        seenHmax <= 1'b1;
        reach[3]++;
        if (axisPhase == 1) begin
          reach[4]++;
          reach[5]++;
        end
        if (axisPhase == 2) reach[6]++;
      end
    end
  end

  resetOutputsZero: assert property (@(posedge clk) disable iff (do_reset)
    !seenHmax |-> (size == 0 && side == 0 && texU == 0 && wallDist == 0))
    else begin
      errs[1]++;
      $display("error reset outputs: expected 0 actual size %0h side %0d texU %0h dist %0h",
               $sampled(size), $sampled(side), $sampled(texU), $sampled(wallDist));
    end

  // Within the walk the address may move by one cell on a single axis
  walkUnitStep: assert property (@(posedge clk) disable iff (do_reset)
    (i_dut.state == TraceStep) |=>
      ((mapRow == $past(mapRow)) && (4'(mapCol - $past(mapCol)) inside {0, 1, 15})) ||
      ((mapCol == $past(mapCol)) && (4'(mapRow - $past(mapRow)) inside {1, 15})))
    else begin
      errs[2]++;
      $display("error walk step: address jumped to row %0d col %0d", mapRow, mapCol);
    end

  hitIsWall: assert property (@(posedge clk) disable iff (do_reset) hmax |-> mapVal)
    else begin
      errs[3]++;
      $display("error hit wall: expected 1 actual %0d", $sampled(mapVal));
    end

  hitSideAxis: assert property (@(posedge clk) disable iff (do_reset)
    hmax |=> (side == lastAxis))
    else begin
      errs[3]++;
      $display("error hit side: expected %0d actual %0d", $sampled(lastAxis), $sampled(side));
    end

  axisDistance: assert property (@(posedge clk) disable iff (do_reset)
    (axisPhase == 1 && hmax) |=> (side == 0 && wallDist == expDist && size == expSize))
    else begin
      errs[4]++;
      $display("error axis distance: expected %0h/%0h actual %0h/%0h side %0d",
               expDist, expSize, $sampled(wallDist), $sampled(size), $sampled(side));
    end

  texturePlain: assert property (@(posedge clk) disable iff (do_reset)
    (axisPhase == 1 && hmax) |=> (texU == expTexU))
    else begin
      errs[5]++;
      $display("error texture plain: expected %0h actual %0h", expTexU, $sampled(texU));
    end

  textureMirror: assert property (@(posedge clk) disable iff (do_reset)
    (axisPhase == 2 && hmax) |=> (texU == expTexU))
    else begin
      errs[6]++;
      $display("error texture mirror: expected %0h actual %0h", expTexU, $sampled(texU));
    end

  // New view vectors take effect through a frame restart
  task automatic startScene(input fixedT px, input fixedT py, input fixedT fx,
                            input fixedT fy, input fixedT vx, input fixedT vy);
    @(posedge clk);
    playerX <= px;
    playerY <= py;
    facingX <= fx;
    facingY <= fy;
    vplaneX <= vx;
    vplaneY <= vy;
    vsync <= 1'b1;
    repeat (2) @(posedge clk);
    vsync <= 1'b0;
  endtask

  // Line end comes every 100 cycles, once the tracer is done with the line
  task automatic runLine();
    int cnt;
    cnt = 0;
    if (timedOut != 0) return;
    while ((cnt < 98 || i_dut.state != TraceDone) && cnt < 500) begin
      @(posedge clk);
      cnt++;
    end
    if (i_dut.state != TraceDone) begin
      timedOut = 1;
      $display("timeout: the tracer did not finish a line within 500 cycles");
    end else begin
      hmax <= 1'b1;
      @(posedge clk);
      hmax <= 1'b0;
      // The presented results are checked on the edge after the pulse
      @(posedge clk);
    end
  endtask

  // Expected results of a ray along X come from a scan of the map model
  task automatic expectAxis(input fixedT px, input fixedT py, input int dir);
    int col;
    int d8;
    col = px[FixedBits-1:FracBits];
    do col += dir; while (!wallMap[py[FixedBits-1:FracBits]][col]);
    if (dir > 0) expDist = fixedT'((col << FracBits) - px);
    else expDist = fixedT'(px - ((col + 1) << FracBits));
    // The size path sees the distance cut to multiples of 8 raw units
    d8 = expDist & 'h7fff8;
    expSize = wallSizeT'(((1 << 24) / d8) >> 4);
    expTexU = (dir > 0) ? py[FracBits-1 -: 6] : ~py[FracBits-1 -: 6];
  endtask

  task automatic reportTest(input int idx, input string name);
    if (reach[idx] == 0) begin
      failCount++;
      $display("test %0d %s: never reached by the stimulus", idx, name);
    end else if (errs[idx] != 0) begin
      failCount++;
      $display("test %0d %s: FAIL with %0d errors", idx, name, errs[idx]);
    end else begin
      $display("test %0d %s: pass over %0d checks", idx, name, reach[idx]);
    end
  endtask

  initial begin
    do_reset = 1'b1;
    vsync = 1'b0;
    hmax = 1'b0;
    {playerX, playerY, facingX, facingY, vplaneX, vplaneY} = '0;
    {walkPhase, axisPhase, timedOut, failCount} = '0;
    for (int i = 1; i <= 6; i++) begin
      errs[i] = 0;
      reach[i] = 0;
    end
    for (int r = 0; r < 16; r++)
      for (int c = 0; c < 16; c++)
        wallMap[r][c] = (r == 0 || r == 15 || c == 0 || c == 15);
    for (int k = 0; k < 12; k++)
      wallMap[1 + $unsigned($random(seed)) % 14][1 + $unsigned($random(seed)) % 14] = 1'b1;
    // Players never start inside a wall
    wallMap[8][7] = 1'b0;
    wallMap[8][3] = 1'b0;
    wallMap[8][12] = 1'b0;
    repeat (3) @(posedge clk);
    do_reset <= 1'b0;
    walkPhase = 1;
    startScene(24'h007800, 24'h0084cd, 24'h00099a, 24'h000ccd, 24'hfff800, 24'h000600);
    repeat (20) runLine();
    walkPhase = 0;
    expectAxis(24'h003666, 24'h00899a, 1);
    axisPhase = 1;
    startScene(24'h003666, 24'h00899a, OneFixed, '0, '0, '0);
    repeat (2) runLine();
    expectAxis(24'h00c4cd, 24'h00899a, -1);
    axisPhase = 2;
    startScene(24'h00c4cd, 24'h00899a, -OneFixed, '0, '0, '0);
    repeat (2) runLine();
    repeat (3) @(posedge clk);
    reportTest(1, "reset outputs");
    reportTest(2, "unit walk steps");
    reportTest(3, "hit wall and side");
    reportTest(4, "axis distance and size");
    reportTest(5, "texture u plain");
    reportTest(6, "texture u mirrored");
    $display("checks done: %0d tests failed, %0d passed", failCount, 6 - failCount);
    if (failCount == 0 && timedOut == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== files.f ====
hdl/fixedPointPkg.sv
hdl/tracerPkg.sv
hdl/rayDirection.sv
hdl/fixedReciprocal.sv
hdl/traceSequencer.sv
hdl/gridWalker.sv
hdl/hitResult.sv
hdl/wallTracer.sv
bench/tbWallTracer.sv

// ==== Makefile ====
# Verilator simulation of the wall tracer testbench

VERILATOR ?= verilator
TOP       ?= tbWallTracer
FILELIST  ?= files.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0 -Wno-fatal
PASSTEXT  ?= TB PASSED

.PHONY: sim clean

# Build, run, and pass only when the pass message shows up in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASSTEXT)"

clean:
	rm -rf $(OBJDIR)
